/* src.f */
+incdir+.
cache_pkg.sv
bus_master.sv
l1_icache.sv
l1_dcache.sv
cpu_wrapper.sv
tb_cpu_wrapper.sv

/* run.sh */
#!/bin/sh
# Build and run the cache wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_wrapper \
    -f src.f \
    -o sim_tb

./obj_dir/sim_tb

/* tb_cpu_wrapper.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_cpu_wrapper
    import cache_pkg::*;
;

    localparam int MEM_WORDS  = 1024;
    localparam int RAND_ITERS = 100;
    // Directed requests plus one fetch and one data access per random iteration
    localparam int TOTAL_REQS = 14 + 2 * RAND_ITERS;

    logic  clk;
    logic  rst;
    logic  i_req_i;
    addr_t i_addr_i;
    word_t i_rdata_o;
    logic  i_wait_o;
    logic  d_req_i;
    logic  d_write_i;
    addr_t d_addr_i;
    word_t d_wdata_i;
    strb_t d_strb_i;
    word_t d_rdata_o;
    logic  d_wait_o;
    logic  ibus_req_o;
    logic  ibus_we_o;
    addr_t ibus_addr_o;
    word_t ibus_wdata_o;
    strb_t ibus_strb_o;
    logic  ibus_ack_i;
    word_t ibus_rdata_i;
    logic  dbus_req_o;
    logic  dbus_we_o;
    addr_t dbus_addr_o;
    word_t dbus_wdata_o;
    strb_t dbus_strb_o;
    logic  dbus_ack_i;
    word_t dbus_rdata_i;

    // Backing memory shared by both buses, and the expected contents
    word_t mem    [MEM_WORDS];
    word_t shadow [MEM_WORDS];

    int    seed = 85551;
    int    ibus_reads = 0;
    int    dbus_reads = 0;
    int    dbus_writes = 0;
    strb_t last_dstrb;
    addr_t last_daddr;
    string test_name;
    word_t exp_i;
    word_t exp_d;
    logic  ireq_prev = 1'b0;
    logic  dreq_prev = 1'b0;
    logic  iack_prev = 1'b0;
    logic  dack_prev = 1'b0;

    cpu_wrapper u_cpu_wrapper (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic expect_count(input string what, input int exp, input int act);
        assert (act == exp)
        else fail_now($sformatf("error %s: %s expected %0d, actual %0d",
                                test_name, what, exp, act));
    endtask

    // Odd multiplier keeps every byte address distinct
    function automatic word_t fill_word(input int unsigned byte_addr);
        return word_t'(byte_addr * 32'h9E37_79B1) ^ 32'h3C5A_0F96;
    endfunction

    function automatic word_t apply_strobes(input word_t old_w, input word_t new_w,
                                            input strb_t s);
        word_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return shadow[a[11:2]];
    endfunction

    task automatic fetch(input addr_t a);
        i_req_i  = 1'b1;
        i_addr_i = a;
        do @(posedge clk); while (i_wait_o);
        @(negedge clk);
        i_req_i = 1'b0;
    endtask

    task automatic data_access(input logic wr, input addr_t a, input word_t w,
                               input strb_t s);
        d_req_i   = 1'b1;
        d_write_i = wr;
        d_addr_i  = a;
        d_wdata_i = w;
        d_strb_i  = s;
        do @(posedge clk); while (d_wait_o);
        @(negedge clk);
        d_req_i   = 1'b0;
        d_write_i = 1'b0;
    endtask

    // Instruction memory model
    initial begin : ibus_model
        int delay;
        forever begin
            @(negedge clk);
            if (ibus_req_o) begin
                delay = $random(seed) & 3;
                repeat (delay) begin
                    @(negedge clk);
                    assert (ibus_req_o)
                    else fail_now("instruction bus master dropped req before ack");
                end
                ibus_rdata_i = mem[ibus_addr_o[11:2]];
                ibus_ack_i   = 1'b1;
                ibus_reads++;
                do @(negedge clk); while (ibus_req_o);
                // Slow ack release
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                ibus_ack_i = 1'b0;
            end
        end
    end

    // Data memory model
    initial begin : dbus_model
        int delay;
        forever begin
            @(negedge clk);
            if (dbus_req_o) begin
                delay = $random(seed) & 3;
                repeat (delay) begin
                    @(negedge clk);
                    assert (dbus_req_o)
                    else fail_now("data bus master dropped req before ack");
                end
                if (dbus_we_o) begin
                    mem[dbus_addr_o[11:2]] = apply_strobes(mem[dbus_addr_o[11:2]],
                                                           dbus_wdata_o, dbus_strb_o);
                    last_dstrb = dbus_strb_o;
                    last_daddr = dbus_addr_o;
                    dbus_writes++;
                end else begin
                    dbus_rdata_i = mem[dbus_addr_o[11:2]];
                    dbus_reads++;
                end
                dbus_ack_i = 1'b1;
                do @(negedge clk); while (dbus_req_o);
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                dbus_ack_i = 1'b0;
            end
        end
    end

    // Bus protocol monitor
    always @(posedge clk) begin
        if (rst) begin
            assert (!(ibus_req_o && !ireq_prev && iack_prev))
            else fail_now("instruction bus master raised req while ack was still high");
            assert (!(dbus_req_o && !dreq_prev && dack_prev))
            else fail_now("data bus master raised req while ack was still high");
            assert (!ibus_we_o && (ibus_strb_o == '0)
                    && (!ibus_req_o || (ibus_wdata_o == '0)))
            else fail_now("instruction bus drove a write");
        end
        ireq_prev = ibus_req_o;
        dreq_prev = dbus_req_o;
        iack_prev = ibus_ack_i;
        dack_prev = dbus_ack_i;
    end

    // Compare every completing core transfer with the reference
    always @(posedge clk) begin
        if (rst && i_req_i && !i_wait_o) begin
            exp_i = expected_word(i_addr_i);
            assert (i_rdata_o == exp_i)
            else fail_now($sformatf("error %s: fetch %h expected %h, actual %h",
                                    test_name, i_addr_i, exp_i, i_rdata_o));
        end
        if (rst && d_req_i && !d_wait_o) begin
            if (d_write_i) begin
                shadow[d_addr_i[11:2]] = apply_strobes(shadow[d_addr_i[11:2]],
                                                       d_wdata_i, d_strb_i);
            end else begin
                exp_d = expected_word(d_addr_i);
                assert (d_rdata_o == exp_d)
                else fail_now($sformatf("error %s: load %h expected %h, actual %h",
                                        test_name, d_addr_i, exp_d, d_rdata_o));
            end
        end
    end

    initial begin : watchdog
        repeat (TOTAL_REQS * 40) @(posedge clk);
        fail_now("watchdog expired, a request never completed");
    end

    initial begin : stimulus
        addr_t f_addr;
        addr_t m_addr;
        word_t w;
        strb_t s;
        logic  wr;
        int    r0;
        int    w0;
        rst          = 1'b0;
        i_req_i      = 1'b0;
        i_addr_i     = '0;
        d_req_i      = 1'b0;
        d_write_i    = 1'b0;
        d_addr_i     = '0;
        d_wdata_i    = '0;
        d_strb_i     = '0;
        ibus_ack_i   = 1'b0;
        ibus_rdata_i = '0;
        dbus_ack_i   = 1'b0;
        dbus_rdata_i = '0;
        test_name    = "reset";
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i * 4);
            shadow[i] = mem[i];
        end
        repeat (4) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        assert (!i_wait_o && !d_wait_o && !ibus_req_o && !dbus_req_o)
        else fail_now("wait or bus req is high after reset");

        test_name = "icache_miss_hit";
        r0 = ibus_reads;
        fetch(32'h040);
        expect_count("ibus reads after miss", `LINE_WORDS, ibus_reads - r0);
        fetch(32'h044);
        fetch(32'h048);
        fetch(32'h04C);
        fetch(32'h040);
        expect_count("ibus reads after hits", `LINE_WORDS, ibus_reads - r0);

        test_name = "dcache_write_hit";
        r0 = dbus_reads;
        w0 = dbus_writes;
        data_access(1'b0, 32'h840, '0, '0);
        expect_count("dbus reads after miss", `LINE_WORDS, dbus_reads - r0);
        data_access(1'b1, 32'h844, 32'hDEAD_BEEF, 4'b0101);
        expect_count("dbus writes", 1, dbus_writes - w0);
        expect_count("write strobes", 4'b0101, last_dstrb);
        expect_count("write address", 32'h844, last_daddr);
        data_access(1'b0, 32'h844, '0, '0);
        expect_count("dbus reads after hit", `LINE_WORDS, dbus_reads - r0);

        test_name = "dcache_write_miss";
        r0 = dbus_reads;
        w0 = dbus_writes;
        data_access(1'b1, 32'h9C8, 32'h1234_5678, 4'b1010);
        expect_count("dbus writes", 1, dbus_writes - w0);
        expect_count("dbus reads on write miss", 0, dbus_reads - r0);
        data_access(1'b0, 32'h9C8, '0, '0);
        expect_count("dbus reads after refill", `LINE_WORDS, dbus_reads - r0);

        // Same index, different tag
        test_name = "conflict_evict";
        r0 = dbus_reads;
        data_access(1'b0, 32'hA04, '0, '0);
        expect_count("dbus reads", `LINE_WORDS, dbus_reads - r0);
        data_access(1'b0, 32'hB04, '0, '0);
        expect_count("dbus reads", 2 * `LINE_WORDS, dbus_reads - r0);
        data_access(1'b0, 32'hA08, '0, '0);
        expect_count("dbus reads", 3 * `LINE_WORDS, dbus_reads - r0);
        data_access(1'b0, 32'hB0C, '0, '0);
        expect_count("dbus reads", 4 * `LINE_WORDS, dbus_reads - r0);

        // Fetch and data regions kept apart since the icache does not snoop
        test_name = "random_mix";
        for (int n = 0; n < RAND_ITERS; n++) begin
            f_addr = addr_t'(($random(seed) & 32'hFF) << 2);
            m_addr = addr_t'(32'h800 + (($random(seed) & 32'hFF) << 2));
            wr     = 1'($random(seed));
            w      = word_t'($random(seed));
            s      = strb_t'($random(seed));
            fork
                fetch(f_addr);
                data_access(wr, m_addr, w, s);
            join
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* cpu_wrapper.sv */
`timescale 1ns/1ps

module cpu_wrapper
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    // Instruction port
    input  logic  i_req_i,
    input  addr_t i_addr_i,
    output word_t i_rdata_o,
    output logic  i_wait_o,
    // Data port
    input  logic  d_req_i,
    input  logic  d_write_i,
    input  addr_t d_addr_i,
    input  word_t d_wdata_i,
    input  strb_t d_strb_i,
    output word_t d_rdata_o,
    output logic  d_wait_o,
    // Instruction bus
    output logic  ibus_req_o,
    output logic  ibus_we_o,
    output addr_t ibus_addr_o,
    output word_t ibus_wdata_o,
    output strb_t ibus_strb_o,
    input  logic  ibus_ack_i,
    input  word_t ibus_rdata_i,
    // Data bus
    output logic  dbus_req_o,
    output logic  dbus_we_o,
    output addr_t dbus_addr_o,
    output word_t dbus_wdata_o,
    output strb_t dbus_strb_o,
    input  logic  dbus_ack_i,
    input  word_t dbus_rdata_i
);

    // Instruction cache to its master
    logic  ic_req;
    logic  ic_write;
    addr_t ic_addr;
    word_t ic_wdata;
    strb_t ic_strb;
    word_t ic_rdata;
    logic  ic_wait;

    // Data cache to its master
    logic  dc_req;
    logic  dc_write;
    addr_t dc_addr;
    word_t dc_wdata;
    strb_t dc_strb;
    word_t dc_rdata;
    logic  dc_wait;

    l1_icache u_l1_icache (
        .clk          (clk      ),
        .rst          (rst      ),
        .core_req_i   (i_req_i  ),
        .core_addr_i  (i_addr_i ),
        .core_rdata_o (i_rdata_o),
        .core_wait_o  (i_wait_o ),
        .mem_req_o    (ic_req   ),
        .mem_write_o  (ic_write ),
        .mem_addr_o   (ic_addr  ),
        .mem_wdata_o  (ic_wdata ),
        .mem_strb_o   (ic_strb  ),
        .mem_rdata_i  (ic_rdata ),
        .mem_wait_i   (ic_wait  )
    );

    l1_dcache u_l1_dcache (
        .clk          (clk      ),
        .rst          (rst      ),
        .core_req_i   (d_req_i  ),
        .core_write_i (d_write_i),
        .core_addr_i  (d_addr_i ),
        .core_wdata_i (d_wdata_i),
        .core_strb_i  (d_strb_i ),
        .core_rdata_o (d_rdata_o),
        .core_wait_o  (d_wait_o ),
        .mem_req_o    (dc_req   ),
        .mem_write_o  (dc_write ),
        .mem_addr_o   (dc_addr  ),
        .mem_wdata_o  (dc_wdata ),
        .mem_strb_o   (dc_strb  ),
        .mem_rdata_i  (dc_rdata ),
        .mem_wait_i   (dc_wait  )
    );

    bus_master u_ibus_master (
        .clk         (clk         ),
        .rst         (rst         ),
        .creq_i      (ic_req      ),
        .cwrite_i    (ic_write    ),
        .caddr_i     (ic_addr     ),
        .cwdata_i    (ic_wdata    ),
        .cstrb_i     (ic_strb     ),
        .crdata_o    (ic_rdata    ),
        .cwait_o     (ic_wait     ),
        .bus_req_o   (ibus_req_o  ),
        .bus_we_o    (ibus_we_o   ),
        .bus_addr_o  (ibus_addr_o ),
        .bus_wdata_o (ibus_wdata_o),
        .bus_strb_o  (ibus_strb_o ),
        .bus_ack_i   (ibus_ack_i  ),
        .bus_rdata_i (ibus_rdata_i)
    );

    bus_master u_dbus_master (
        .clk         (clk         ),
        .rst         (rst         ),
        .creq_i      (dc_req      ),
        .cwrite_i    (dc_write    ),
        .caddr_i     (dc_addr     ),
        .cwdata_i    (dc_wdata    ),
        .cstrb_i     (dc_strb     ),
        .crdata_o    (dc_rdata    ),
        .cwait_o     (dc_wait     ),
        .bus_req_o   (dbus_req_o  ),
        .bus_we_o    (dbus_we_o   ),
        .bus_addr_o  (dbus_addr_o ),
        .bus_wdata_o (dbus_wdata_o),
        .bus_strb_o  (dbus_strb_o ),
        .bus_ack_i   (dbus_ack_i  ),
        .bus_rdata_i (dbus_rdata_i)
    );

endmodule

/* l1_dcache.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module l1_dcache
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  core_req_i,
    input  logic  core_write_i,
    input  addr_t core_addr_i,
    input  word_t core_wdata_i,
    input  strb_t core_strb_i,
    output word_t core_rdata_o,
    output logic  core_wait_o,
    output logic  mem_req_o,
    output logic  mem_write_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o,
    output strb_t mem_strb_o,
    input  word_t mem_rdata_i,
    input  logic  mem_wait_i
);

    dcache_state_t state_q;
    logic [`OFFSET_BITS-1:0] word_cnt_q;
    logic req_q;

    logic [`CACHE_LINES-1:0] valid_q;
    tag_t  tag_q  [`CACHE_LINES];
    word_t data_q [`CACHE_LINES][`LINE_WORDS];

    index_t line_idx;
    logic [`OFFSET_BITS-1:0] word_off;
    tag_t req_tag;
    logic hit;
    logic in_write;
    logic write_hit;
    logic word_done;
    logic write_done;
    logic last_word;
    logic done;
    addr_t refill_addr;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < `STRB_BITS; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign line_idx = core_addr_i[`OFFSET_BITS+2 +: `INDEX_BITS];
    assign word_off = core_addr_i[2 +: `OFFSET_BITS];
    assign req_tag  = core_addr_i[`ADDR_BITS-1 -: `TAG_BITS];

    assign hit       = valid_q[line_idx] && (tag_q[line_idx] == req_tag);
    assign in_write  = (state_q == DC_WRITE_THRU);
    assign write_hit = (state_q == DC_IDLE) && core_req_i && core_write_i && hit;

    assign word_done  = (state_q == DC_REFILL) && req_q && !mem_wait_i;
    assign write_done = in_write && req_q && !mem_wait_i;
    assign last_word  = (word_cnt_q == `OFFSET_BITS'(`LINE_WORDS-1));

    // Only read hits finish straight from idle
    assign done = ((state_q == DC_IDLE) && !core_write_i && hit)
               || (state_q == DC_RESPOND);

    assign core_wait_o  = core_req_i && !done;
    assign core_rdata_o = data_q[line_idx][word_off];

    assign refill_addr = {core_addr_i[`ADDR_BITS-1:`OFFSET_BITS+2], word_cnt_q, 2'b00};

    assign mem_req_o   = ((state_q == DC_REFILL) || in_write) && req_q;
    assign mem_write_o = in_write;
    assign mem_addr_o  = in_write ? {core_addr_i[`ADDR_BITS-1:2], 2'b00} : refill_addr;
    assign mem_wdata_o = core_wdata_i;
    assign mem_strb_o  = in_write ? core_strb_i : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= DC_IDLE;
            word_cnt_q <= '0;
            req_q      <= 1'b0;
            valid_q    <= '0;
        end else begin
            case (state_q)
                DC_IDLE: begin
                    if (core_req_i && core_write_i) begin
                        // No allocation on a write miss
                        req_q   <= 1'b1;
                        state_q <= DC_WRITE_THRU;
                    end else if (core_req_i && !hit) begin
                        valid_q[line_idx] <= 1'b0;
                        word_cnt_q        <= '0;
                        req_q             <= 1'b1;
                        state_q           <= DC_REFILL;
                    end
                end
                DC_REFILL: begin
                    if (word_done) begin
                        req_q      <= 1'b0;
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            valid_q[line_idx] <= 1'b1;
                            state_q           <= DC_RESPOND;
                        end
                    end else if (!req_q) begin
                        req_q <= 1'b1;
                    end
                end
                DC_WRITE_THRU: begin
                    if (write_done) begin
                        req_q   <= 1'b0;
                        state_q <= DC_RESPOND;
                    end
                end
                DC_RESPOND: begin
                    state_q <= DC_IDLE;
                end
                default: begin
                    state_q <= DC_IDLE;
                end
            endcase
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (write_hit) begin
            // Merge on accept, memory gets the same bytes afterwards
            data_q[line_idx][word_off] <= merge_bytes(data_q[line_idx][word_off],
                                                      core_wdata_i, core_strb_i);
        end
        if (word_done) begin
            data_q[line_idx][word_cnt_q] <= mem_rdata_i;
            if (last_word) begin
                tag_q[line_idx] <= req_tag;
            end
        end
    end

endmodule

/* l1_icache.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module l1_icache
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  core_req_i,
    input  addr_t core_addr_i,
    output word_t core_rdata_o,
    output logic  core_wait_o,
    output logic  mem_req_o,
    output logic  mem_write_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o,
    output strb_t mem_strb_o,
    input  word_t mem_rdata_i,
    input  logic  mem_wait_i
);

    icache_state_t state_q;
    logic [`OFFSET_BITS-1:0] word_cnt_q;
    logic req_q;

    logic [`CACHE_LINES-1:0] valid_q;
    tag_t  tag_q  [`CACHE_LINES];
    word_t data_q [`CACHE_LINES][`LINE_WORDS];

    index_t line_idx;
    logic [`OFFSET_BITS-1:0] word_off;
    tag_t req_tag;
    logic hit;
    logic word_done;
    logic last_word;
    logic done;

    assign line_idx = core_addr_i[`OFFSET_BITS+2 +: `INDEX_BITS];
    assign word_off = core_addr_i[2 +: `OFFSET_BITS];
    assign req_tag  = core_addr_i[`ADDR_BITS-1 -: `TAG_BITS];

    // Compare against registered arrays, so a hit answers at once
    assign hit = valid_q[line_idx] && (tag_q[line_idx] == req_tag);

    assign word_done = (state_q == IC_REFILL) && req_q && !mem_wait_i;
    assign last_word = (word_cnt_q == `OFFSET_BITS'(`LINE_WORDS-1));

    assign done = ((state_q == IC_IDLE) && hit) || (state_q == IC_RESPOND);

    assign core_wait_o  = core_req_i && !done;
    assign core_rdata_o = data_q[line_idx][word_off];

    // Read-only path toward the master
    assign mem_req_o   = (state_q == IC_REFILL) && req_q;
    assign mem_addr_o  = {core_addr_i[`ADDR_BITS-1:`OFFSET_BITS+2], word_cnt_q, 2'b00};
    assign mem_write_o = 1'b0;
    assign mem_wdata_o = '0;
    assign mem_strb_o  = '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= IC_IDLE;
            word_cnt_q <= '0;
            req_q      <= 1'b0;
            valid_q    <= '0;
        end else begin
            case (state_q)
                IC_IDLE: begin
                    if (core_req_i && !hit) begin
                        // Old line is dropped before it is overwritten
                        valid_q[line_idx] <= 1'b0;
                        word_cnt_q        <= '0;
                        req_q             <= 1'b1;
                        state_q           <= IC_REFILL;
                    end
                end
                IC_REFILL: begin
                    if (word_done) begin
                        req_q      <= 1'b0;
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            valid_q[line_idx] <= 1'b1;
                            state_q           <= IC_RESPOND;
                        end
                    end else if (!req_q) begin
                        // One idle cycle between words
                        req_q <= 1'b1;
                    end
                end
                IC_RESPOND: begin
                    state_q <= IC_IDLE;
                end
                default: begin
                    state_q <= IC_IDLE;
                end
            endcase
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (word_done) begin
            data_q[line_idx][word_cnt_q] <= mem_rdata_i;
            if (last_word) begin
                tag_q[line_idx] <= req_tag;
            end
        end
    end

endmodule

/* bus_master.sv */
`timescale 1ns/1ps

module bus_master
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  creq_i,
    input  logic  cwrite_i,
    input  addr_t caddr_i,
    input  word_t cwdata_i,
    input  strb_t cstrb_i,
    output word_t crdata_o,
    output logic  cwait_o,
    output logic  bus_req_o,
    output logic  bus_we_o,
    output addr_t bus_addr_o,
    output word_t bus_wdata_o,
    output strb_t bus_strb_o,
    input  logic  bus_ack_i,
    input  word_t bus_rdata_i
);

    bm_state_t state_q;
    logic  we_q;
    strb_t strb_q;
    addr_t addr_q;
    word_t wdata_q;
    word_t rdata_q;
    logic  start;

    assign start = (state_q == BM_IDLE) && creq_i;

    assign bus_req_o   = (state_q == BM_REQ_HIGH);
    assign bus_we_o    = we_q;
    assign bus_strb_o  = strb_q;
    assign bus_addr_o  = addr_q;
    assign bus_wdata_o = wdata_q;

    // Cache sees exactly one ready cycle per transfer
    assign cwait_o  = (state_q != BM_DONE);
    assign crdata_o = rdata_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= BM_IDLE;
            we_q    <= 1'b0;
            strb_q  <= '0;
        end else begin
            case (state_q)
                BM_IDLE: begin
                    if (creq_i) begin
                        we_q    <= cwrite_i;
                        strb_q  <= cstrb_i;
                        state_q <= BM_REQ_HIGH;
                    end
                end
                BM_REQ_HIGH: begin
                    if (bus_ack_i) begin
                        state_q <= BM_ACK_LOW;
                    end
                end
                BM_ACK_LOW: begin
                    // Memory must release ack before the next req
                    if (!bus_ack_i) begin
                        state_q <= BM_DONE;
                    end
                end
                BM_DONE: begin
                    state_q <= BM_IDLE;
                end
                default: begin
                    state_q <= BM_IDLE;
                end
            endcase
        end
    end

    // Operand and read data registers
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= caddr_i;
            wdata_q <= cwdata_i;
        end
        if ((state_q == BM_REQ_HIGH) && bus_ack_i) begin
            rdata_q <= bus_rdata_i;
        end
    end

endmodule

/* cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`ADDR_BITS-1:0]  addr_t;
    typedef logic [`DATA_BITS-1:0]  word_t;
    typedef logic [`STRB_BITS-1:0]  strb_t;
    typedef logic [`TAG_BITS-1:0]   tag_t;
    typedef logic [`INDEX_BITS-1:0] index_t;

    // Instruction cache FSM
    typedef enum logic [1:0] {
        IC_IDLE,
        IC_REFILL,
        IC_RESPOND
    } icache_state_t;

    // Data cache FSM
    typedef enum logic [1:0] {
        DC_IDLE,
        DC_REFILL,
        DC_WRITE_THRU,
        DC_RESPOND
    } dcache_state_t;

    // Four-phase bus master FSM
    typedef enum logic [1:0] {
        BM_IDLE,
        BM_REQ_HIGH,
        BM_ACK_LOW,
        BM_DONE
    } bm_state_t;

endpackage

/* cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Bus and word widths
`define ADDR_BITS   32
`define DATA_BITS   32
`define STRB_BITS   4

// Direct-mapped geometry
`define LINE_WORDS  4
`define CACHE_LINES 16
`define INDEX_BITS  4
`define OFFSET_BITS 2

// Tag overlaps the upper index bits
`define TAG_BITS    26

`endif
